//--- filelist.f
logic/cps_mem_pkg.sv
logic/slot_map.sv
logic/slot_arbiter.sv
logic/read_return.sv
logic/cps_sdram_mux.sv
testbench/mux_checker.sv
testbench/tb_cps_sdram_mux.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SDRAM multiplexer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_cps_sdram_mux \
    -Mdir obj_dir -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Test completed successfully" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

//--- testbench/tb_cps_sdram_mux.sv
// Testbench top that runs the test table against the SDRAM multiplexer and models the SDRAM controller
`default_nettype none

module tb_cps_sdram_mux import cps_mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS = 12;
    localparam int ROW_EXP  = 4;
    localparam int WAIT_MAX = 300;

    logic        VB = 1'b0;
    logic        rst, downloading;
    logic        main_rom_cs, main_ram_cs, main_vram_cs, main_rnw;
    logic [20:0] main_rom_addr;
    logic [16:0] ram_addr;
    word_t       main_dout;
    logic [1:0]  dsn;
    logic        gfx_cs, adpcm_cs, snd_cs;
    sdram_addr_t gfx_addr;
    logic [17:0] adpcm_addr;
    logic [15:0] snd_addr;
    word_t       main_rom_data, main_ram_data, data_write;
    rdata_t      gfx_data;
    logic [7:0]  adpcm_data, snd_data;
    logic        main_rom_ok, main_ram_ok, gfx_ok, adpcm_ok, snd_ok;
    logic        sdram_req, sdram_rnw;
    sdram_addr_t sdram_addr;
    bank_t       sdram_bank;
    logic [1:0]  sdram_wrmask;
    logic        sdram_ack = 1'b0;
    logic        data_rdy = 1'b0;
    rdata_t      data_read = '0;
    logic        timed_out = 1'b0;

    // SDRAM model state
    int          seed = 32'habfb_ed57;
    int          cyc = 0;
    int          ack_cnt = 0;
    logic        ack_busy = 1'b0;
    logic        slow = 1'b0;
    sdram_addr_t rq_addr [$];
    int          rq_due [$];

    // Stimulus table with select bits ordered {snd, adpcm, gfx, vram, ram, rom}
    string       t_name [NUM_ROWS];
    logic [5:0]  t_sel [NUM_ROWS];
    sdram_addr_t t_addr [NUM_ROWS];
    logic        t_rnw [NUM_ROWS];
    word_t       t_wdata [NUM_ROWS];
    logic [1:0]  t_mask [NUM_ROWS];
    logic        t_dl [NUM_ROWS];
    logic        t_slow [NUM_ROWS];
    int          t_n [NUM_ROWS];
    slot_id_t    t_es [NUM_ROWS][ROW_EXP];
    sdram_addr_t t_ea [NUM_ROWS][ROW_EXP];
    bank_t       t_eb [NUM_ROWS][ROW_EXP];
    rdata_t      t_ed [NUM_ROWS][ROW_EXP];

    cps_sdram_mux dut (.*);
    mux_checker   u_chk (.*);

    always #2 VB = ~VB;

    // SDRAM model acknowledges after 1 to 3 cycles and returns reads in request order
    always @(posedge VB) begin
        #1;
        cyc = cyc + 1;
        sdram_ack = 1'b0;
        data_rdy = 1'b0;
        if (rst) begin
            ack_busy = 1'b0;
            rq_addr.delete();
            rq_due.delete();
        end else begin
            if (ack_busy) begin
                ack_cnt = ack_cnt - 1;
                if (ack_cnt == 0) begin
                    sdram_ack = 1'b1;
                    ack_busy = 1'b0;
                    if (sdram_rnw) begin
                        rq_addr.push_back(sdram_addr);
                        rq_due.push_back(cyc + (slow ? 10 : 2));
                    end
                end
            end else if (sdram_req) begin
                ack_busy = 1'b1;
                ack_cnt = 1 + int'($unsigned($random(seed)) % 3);
            end
            if (rq_due.size() > 0 && rq_due[0] <= cyc) begin
                data_rdy = 1'b1;
                data_read = {~rq_addr[0][15:0], rq_addr[0][15:0]};
                void'(rq_addr.pop_front());
                void'(rq_due.pop_front());
            end
        end
    end

    task automatic set_row(input int r, input string name, input logic [5:0] sel,
                           input sdram_addr_t addr, input logic rnw, input word_t wdata,
                           input logic [1:0] mask, input logic dl, input logic slw);
        t_name[r] = name;
        t_sel[r] = sel;
        t_addr[r] = addr;
        t_rnw[r] = rnw;
        t_wdata[r] = wdata;
        t_mask[r] = mask;
        t_dl[r] = dl;
        t_slow[r] = slw;
        t_n[r] = 0;
    endtask

    // Expected issues in the order the SDRAM should see them
    task automatic add_issue(input int r, input slot_id_t s, input sdram_addr_t a,
                             input bank_t b, input rdata_t d);
        t_es[r][t_n[r]] = s;
        t_ea[r][t_n[r]] = a;
        t_eb[r][t_n[r]] = b;
        t_ed[r][t_n[r]] = d;
        t_n[r] = t_n[r] + 1;
    endtask

    task automatic fill_table();
        set_row(0, "rom_read", 6'b000001, 22'h0A_BCDE, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(0, SLOT_MAIN_ROM, 22'h0A_BCDE, BANK_CPU, 32'h0000_BCDE);
        set_row(1, "gfx_read", 6'b001000, 22'h3F_0102, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(1, SLOT_GFX, 22'h3F_0102, BANK_GFX, 32'hFEFD_0102);
        set_row(2, "adpcm_even", 6'b010000, 22'h02_4680, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(2, SLOT_ADPCM, 22'h02_2340, BANK_SOUND, 32'h0000_0040);
        set_row(3, "adpcm_odd", 6'b010000, 22'h02_4681, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(3, SLOT_ADPCM, 22'h02_2340, BANK_SOUND, 32'h0000_0023);
        set_row(4, "snd_even", 6'b100000, 22'h00_BEEE, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(4, SLOT_SOUND, 22'h00_5F77, BANK_SOUND, 32'h0000_0077);
        set_row(5, "snd_odd", 6'b100000, 22'h00_BEEF, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(5, SLOT_SOUND, 22'h00_5F77, BANK_SOUND, 32'h0000_005F);
        set_row(6, "ram_read", 6'b000010, 22'h01_2345, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(6, SLOT_MAIN_RAM, 22'h21_2345, BANK_CPU, 32'h0000_2345);
        set_row(7, "vram_read", 6'b000100, 22'h00_0ABC, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(7, SLOT_MAIN_RAM, 22'h30_0ABC, BANK_CPU, 32'h0000_0ABC);
        set_row(8, "ram_write", 6'b000010, 22'h00_0010, 1'b0, 16'hA55A, 2'b01, 1'b0, 1'b0);
        add_issue(8, SLOT_MAIN_RAM, 22'h20_0010, BANK_CPU, 32'h0);
        set_row(9, "three_at_once", 6'b101001, 22'h00_1235, 1'b1, 16'h0, 2'b11, 1'b0, 1'b0);
        add_issue(9, SLOT_MAIN_ROM, 22'h00_1235, BANK_CPU, 32'h0000_1235);
        add_issue(9, SLOT_GFX, 22'h00_1235, BANK_GFX, 32'hEDCA_1235);
        add_issue(9, SLOT_SOUND, 22'h00_091A, BANK_SOUND, 32'h0000_0009);
        set_row(10, "slow_return", 6'b111001, 22'h00_2468, 1'b1, 16'h0, 2'b11, 1'b0, 1'b1);
        add_issue(10, SLOT_MAIN_ROM, 22'h00_2468, BANK_CPU, 32'h0000_2468);
        add_issue(10, SLOT_GFX, 22'h00_2468, BANK_GFX, 32'hDB97_2468);
        add_issue(10, SLOT_ADPCM, 22'h01_1234, BANK_SOUND, 32'h0000_0034);
        add_issue(10, SLOT_SOUND, 22'h00_1234, BANK_SOUND, 32'h0000_0034);
        set_row(11, "download_hold", 6'b000001, 22'h00_0777, 1'b1, 16'h0, 2'b11, 1'b1, 1'b0);
        add_issue(11, SLOT_MAIN_ROM, 22'h00_0777, BANK_CPU, 32'h0000_0777);
    endtask

    initial begin
        rst = 1'b1;
        downloading = 1'b0;
        {main_rom_cs, main_ram_cs, main_vram_cs, gfx_cs, adpcm_cs, snd_cs} = '0;
        main_rnw = 1'b1;
        main_rom_addr = '0;
        ram_addr = '0;
        main_dout = '0;
        dsn = 2'b11;
        gfx_addr = '0;
        adpcm_addr = '0;
        snd_addr = '0;
        fill_table();
        for (int i = 0; i < 4; i++) begin
            @(posedge VB);
        end
        #1;
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            int waited;
            u_chk.begin_test(t_name[r], t_n[r], t_rnw[r], t_mask[r], t_wdata[r], t_slow[r]);
            for (int k = 0; k < t_n[r]; k++) begin
                u_chk.add_expect(k, t_es[r][k], t_ea[r][k], t_eb[r][k], t_ed[r][k]);
            end
            slow = t_slow[r];
            downloading = t_dl[r];
            main_rom_addr = t_addr[r][20:0];
            ram_addr = t_addr[r][16:0];
            gfx_addr = t_addr[r];
            adpcm_addr = t_addr[r][17:0];
            snd_addr = t_addr[r][15:0];
            main_rnw = t_rnw[r];
            main_dout = t_wdata[r];
            dsn = t_mask[r];
            {snd_cs, adpcm_cs, gfx_cs, main_vram_cs, main_ram_cs, main_rom_cs} = t_sel[r];
            // Downloading blocks new requests for 20 cycles
            if (t_dl[r]) begin
                for (int i = 0; i < 20; i++) begin
                    @(posedge VB);
                end
                #1;
                downloading = 1'b0;
            end
            waited = 0;
            while (u_chk.oks_seen < t_n[r] && waited < WAIT_MAX) begin
                @(posedge VB);
                #1;
                if (main_rom_ok) main_rom_cs = 1'b0;
                if (main_ram_ok) {main_ram_cs, main_vram_cs} = 2'b00;
                if (gfx_ok) gfx_cs = 1'b0;
                if (adpcm_ok) adpcm_cs = 1'b0;
                if (snd_ok) snd_cs = 1'b0;
                waited++;
            end
            if (waited >= WAIT_MAX) begin
                u_chk.flag_event("timed out waiting for client ready strobes");
                timed_out = 1'b1;
            end else begin
                for (int i = 0; i < 2; i++) begin
                    @(posedge VB);
                end
                #1;
            end
            u_chk.end_test();
        end
        u_chk.final_report();
        if (u_chk.errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mux_checker.sv
// Testbench monitor that compares SDRAM requests and client returns of the SDRAM multiplexer
`default_nettype none

module mux_checker import cps_mem_pkg::*; (
    input logic        VB,
    input logic        downloading,
    input logic        sdram_req,
    input logic        sdram_ack,
    input sdram_addr_t sdram_addr,
    input bank_t       sdram_bank,
    input logic        sdram_rnw,
    input logic [1:0]  sdram_wrmask,
    input word_t       data_write,
    input logic        main_rom_ok,
    input logic        main_ram_ok,
    input logic        gfx_ok,
    input logic        adpcm_ok,
    input logic        snd_ok,
    input word_t       main_rom_data,
    input word_t       main_ram_data,
    input rdata_t      gfx_data,
    input logic [7:0]  adpcm_data,
    input logic [7:0]  snd_data
);

    timeunit 1ns;
    timeprecision 1ps;

    string       name = "idle";
    int          n_exp = 0;
    logic        exp_rnw = 1'b1;
    logic [1:0]  exp_mask;
    word_t       exp_wdata;
    logic        exp_slow = 1'b0;
    slot_id_t    e_slot [4];
    sdram_addr_t e_addr [4];
    bank_t       e_bank [4];
    rdata_t      e_data [4];
    int          issues = 0;
    int          oks_seen = 0;
    int          peak = 0;
    int          errors = 0;
    int          test_errs = 0;
    int          tests = 0;
    int          failed = 0;

    task automatic begin_test(input string nm, input int n, input logic rnw,
                              input logic [1:0] mask, input word_t wdata, input logic slw);
        name = nm;
        n_exp = n;
        exp_rnw = rnw;
        exp_mask = mask;
        exp_wdata = wdata;
        exp_slow = slw;
        issues = 0;
        oks_seen = 0;
        peak = 0;
        test_errs = 0;
    endtask

    task automatic add_expect(input int k, input slot_id_t s, input sdram_addr_t a,
                              input bank_t b, input rdata_t d);
        e_slot[k] = s;
        e_addr[k] = a;
        e_bank[k] = b;
        e_data[k] = d;
    endtask

    task automatic flag_value(input string what, input rdata_t exp, input rdata_t act);
        $display("[ERROR] %s: %s expected %h actual %h", name, what, exp, act);
        errors++;
        test_errs++;
    endtask

    task automatic flag_event(input string msg);
        $display("[ERROR] %s: %s", name, msg);
        errors++;
        test_errs++;
    endtask

    // One compare per cycle of the SDRAM side and the client strobes
    always @(negedge VB) begin
        logic [NUM_SLOTS-1:0] oks;
        slot_id_t s;
        rdata_t got;
        if (downloading && sdram_req) flag_event("sdram_req raised while downloading");
        if (sdram_req && sdram_ack) begin
            if (issues >= n_exp) begin
                flag_event("unexpected SDRAM request");
            end else begin
                if (sdram_addr != e_addr[issues])
                    flag_value("sdram_addr", rdata_t'(e_addr[issues]), rdata_t'(sdram_addr));
                if (sdram_bank != e_bank[issues])
                    flag_value("sdram_bank", rdata_t'(e_bank[issues]), rdata_t'(sdram_bank));
                if (sdram_rnw != exp_rnw)
                    flag_value("sdram_rnw", rdata_t'(exp_rnw), rdata_t'(sdram_rnw));
                if (!exp_rnw && sdram_wrmask != exp_mask)
                    flag_value("sdram_wrmask", rdata_t'(exp_mask), rdata_t'(sdram_wrmask));
                if (!exp_rnw && data_write != exp_wdata)
                    flag_value("data_write", rdata_t'(exp_wdata), rdata_t'(data_write));
            end
            issues++;
        end
        oks = {snd_ok, adpcm_ok, gfx_ok, main_ram_ok, main_rom_ok};
        if (|oks) begin
            if ($countones(oks) != 1 || oks_seen >= n_exp) begin
                flag_event("unexpected ready pulse");
            end else begin
                s = '0;
                for (int i = 0; i < NUM_SLOTS; i++) begin
                    if (oks[i]) s = slot_id_t'(i);
                end
                case (s)
                    SLOT_MAIN_ROM: got = rdata_t'(main_rom_data);
                    SLOT_MAIN_RAM: got = rdata_t'(main_ram_data);
                    SLOT_GFX:      got = gfx_data;
                    SLOT_ADPCM:    got = rdata_t'(adpcm_data);
                    default:       got = rdata_t'(snd_data);
                endcase
                if (s != e_slot[oks_seen])
                    flag_value("ready slot", rdata_t'(e_slot[oks_seen]), rdata_t'(s));
                else if (exp_rnw && got != e_data[oks_seen])
                    flag_value("client data", e_data[oks_seen], got);
            end
            oks_seen++;
        end
        if (issues - oks_seen > peak) peak = issues - oks_seen;
    end

    task automatic end_test();
        if (oks_seen != n_exp) flag_event("wrong number of ready pulses");
        if (exp_slow && peak < 2) flag_event("reads did not overlap with slow data return");
        tests++;
        if (test_errs != 0) begin
            failed++;
            $display("FAIL %s", name);
        end else begin
            $display("PASS %s", name);
        end
    endtask

    task automatic final_report();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests, tests - failed, failed, errors);
    endtask

endmodule

`default_nettype wire

//--- logic/cps_sdram_mux.sv
// Top of the SDRAM multiplexer, sharing one SDRAM controller among the five board clients
`default_nettype none

module cps_sdram_mux import cps_mem_pkg::*; (
    input  logic        VB,
    input  logic        rst,
    input  logic        downloading,
    // Main CPU
    input  logic        main_rom_cs,
    input  logic [20:0] main_rom_addr,
    output word_t       main_rom_data,
    output logic        main_rom_ok,
    input  logic        main_ram_cs,
    input  logic        main_vram_cs,
    input  logic        main_rnw,
    input  logic [16:0] ram_addr,
    input  word_t       main_dout,
    input  logic [1:0]  dsn,
    output word_t       main_ram_data,
    output logic        main_ram_ok,
    // Graphics
    input  logic        gfx_cs,
    input  sdram_addr_t gfx_addr,
    output rdata_t      gfx_data,
    output logic        gfx_ok,
    // Sound
    input  logic        adpcm_cs,
    input  logic [17:0] adpcm_addr,
    output logic [7:0]  adpcm_data,
    output logic        adpcm_ok,
    input  logic        snd_cs,
    input  logic [15:0] snd_addr,
    output logic [7:0]  snd_data,
    output logic        snd_ok,
    // SDRAM controller
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    output bank_t       sdram_bank,
    output logic        sdram_rnw,
    output logic [1:0]  sdram_wrmask,
    output word_t       data_write,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  rdata_t      data_read
);

    logic [NUM_SLOTS-1:0] pending;
    sdram_addr_t          map_addr [NUM_SLOTS];
    bank_t                map_bank [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] map_lsb;
    logic                 wr_req;
    logic [1:0]           wr_mask;
    word_t                wr_data;
    logic                 grant;
    slot_id_t             grant_slot;
    logic                 issue_write;
    logic                 issue_lsb;
    logic                 queue_full;

    slot_map u_map (
        .VB            (VB),
        .rst           (rst),
        .main_rom_cs   (main_rom_cs),
        .main_rom_addr (main_rom_addr),
        .main_ram_cs   (main_ram_cs),
        .main_vram_cs  (main_vram_cs),
        .main_rnw      (main_rnw),
        .ram_addr      (ram_addr),
        .main_dout     (main_dout),
        .dsn           (dsn),
        .gfx_cs        (gfx_cs),
        .gfx_addr      (gfx_addr),
        .adpcm_cs      (adpcm_cs),
        .adpcm_addr    (adpcm_addr),
        .snd_cs        (snd_cs),
        .snd_addr      (snd_addr),
        .grant         (grant),
        .grant_slot    (grant_slot),
        .pending       (pending),
        .map_addr      (map_addr),
        .map_bank      (map_bank),
        .map_lsb       (map_lsb),
        .wr_req        (wr_req),
        .wr_mask       (wr_mask),
        .wr_data       (wr_data)
    );

    slot_arbiter u_arb (
        .VB           (VB),
        .rst          (rst),
        .downloading  (downloading),
        .pending      (pending),
        .map_addr     (map_addr),
        .map_bank     (map_bank),
        .wr_req       (wr_req),
        .wr_mask      (wr_mask),
        .wr_data      (wr_data),
        .map_lsb      (map_lsb),
        .sdram_ack    (sdram_ack),
        .queue_full   (queue_full),
        .sdram_req    (sdram_req),
        .sdram_addr   (sdram_addr),
        .sdram_bank   (sdram_bank),
        .sdram_rnw    (sdram_rnw),
        .sdram_wrmask (sdram_wrmask),
        .data_write   (data_write),
        .grant        (grant),
        .grant_slot   (grant_slot),
        .issue_write  (issue_write),
        .issue_lsb    (issue_lsb)
    );

    read_return u_ret (
        .VB            (VB),
        .rst           (rst),
        .grant         (grant),
        .grant_slot    (grant_slot),
        .issue_write   (issue_write),
        .issue_lsb     (issue_lsb),
        .data_rdy      (data_rdy),
        .data_read     (data_read),
        .queue_full    (queue_full),
        .main_rom_data (main_rom_data),
        .main_ram_data (main_ram_data),
        .gfx_data      (gfx_data),
        .adpcm_data    (adpcm_data),
        .snd_data      (snd_data),
        .main_rom_ok   (main_rom_ok),
        .main_ram_ok   (main_ram_ok),
        .gfx_ok        (gfx_ok),
        .adpcm_ok      (adpcm_ok),
        .snd_ok        (snd_ok)
    );

endmodule

`default_nettype wire

//--- logic/read_return.sv
// Return stage of the SDRAM multiplexer: in-order read tags, data routing and client ready pulses
`default_nettype none

module read_return import cps_mem_pkg::*; (
    input  logic     VB,
    input  logic     rst,
    input  logic     grant,
    input  slot_id_t grant_slot,
    input  logic     issue_write,
    input  logic     issue_lsb,
    input  logic     data_rdy,
    input  rdata_t   data_read,
    output logic     queue_full,
    output word_t    main_rom_data,
    output word_t    main_ram_data,
    output rdata_t   gfx_data,
    output logic [7:0] adpcm_data,
    output logic [7:0] snd_data,
    output logic     main_rom_ok,
    output logic     main_ram_ok,
    output logic     gfx_ok,
    output logic     adpcm_ok,
    output logic     snd_ok
);

    slot_id_t             tag_slot [TAG_DEPTH];
    logic [TAG_DEPTH-1:0] tag_lsb;
    logic [TAG_PTR_W-1:0] wr_ptr;
    logic [TAG_PTR_W-1:0] rd_ptr;
    logic [TAG_PTR_W:0]   count;
    logic                 push;
    logic                 pop;
    slot_id_t             head_slot;
    logic                 head_lsb;
    logic [7:0]           head_byte;
    logic [NUM_SLOTS-1:0] ok_q;
    logic [NUM_SLOTS-1:0] rd_hit;
    logic [NUM_SLOTS-1:0] wr_hit;

    // Only reads wait for data
    assign push = grant & ~issue_write;
    assign pop  = data_rdy && (count != '0);

    assign queue_full = (count == (TAG_PTR_W + 1)'(TAG_DEPTH));
    assign head_slot  = tag_slot[rd_ptr];
    assign head_lsb   = tag_lsb[rd_ptr];
    assign head_byte  = head_lsb ? data_read[15:8] : data_read[7:0];

    assign rd_hit = NUM_SLOTS'(pop) << head_slot;
    assign wr_hit = NUM_SLOTS'(grant & issue_write) << grant_slot;

    always_ff @(posedge VB) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ok_q   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (TAG_PTR_W + 1)'(push) - (TAG_PTR_W + 1)'(pop);
            ok_q  <= rd_hit | wr_hit;
        end
    end

    // Tag storage and client data registers
    always_ff @(posedge VB) begin
        if (push) begin
            tag_slot[wr_ptr] <= grant_slot;
            tag_lsb[wr_ptr]  <= issue_lsb;
        end
        if (rd_hit[SLOT_MAIN_ROM]) main_rom_data <= data_read[15:0];
        if (rd_hit[SLOT_MAIN_RAM]) main_ram_data <= data_read[15:0];
        if (rd_hit[SLOT_GFX])      gfx_data      <= data_read;
        if (rd_hit[SLOT_ADPCM])    adpcm_data    <= head_byte;
        if (rd_hit[SLOT_SOUND])    snd_data      <= head_byte;
    end

    assign main_rom_ok = ok_q[SLOT_MAIN_ROM];
    assign main_ram_ok = ok_q[SLOT_MAIN_RAM];
    assign gfx_ok      = ok_q[SLOT_GFX];
    assign adpcm_ok    = ok_q[SLOT_ADPCM];
    assign snd_ok      = ok_q[SLOT_SOUND];

endmodule

`default_nettype wire

//--- logic/slot_arbiter.sv
// Arbiter stage of the SDRAM multiplexer: fixed priority pick, request held until acknowledged
`default_nettype none

module slot_arbiter import cps_mem_pkg::*; (
    input  logic                 VB,
    input  logic                 rst,
    input  logic                 downloading,
    input  logic [NUM_SLOTS-1:0] pending,
    input  sdram_addr_t          map_addr [NUM_SLOTS],
    input  bank_t                map_bank [NUM_SLOTS],
    input  logic                 wr_req,
    input  logic [1:0]           wr_mask,
    input  word_t                wr_data,
    input  logic [NUM_SLOTS-1:0] map_lsb,
    input  logic                 sdram_ack,
    input  logic                 queue_full,
    output logic                 sdram_req,
    output sdram_addr_t          sdram_addr,
    output bank_t                sdram_bank,
    output logic                 sdram_rnw,
    output logic [1:0]           sdram_wrmask,
    output word_t                data_write,
    output logic                 grant,
    output slot_id_t             grant_slot,
    output logic                 issue_write,
    output logic                 issue_lsb
);

    arb_state_t state;
    slot_id_t   next_slot;
    slot_id_t   cur_slot;
    logic       cur_lsb;
    logic       start;
    logic       next_wr;

    // Lowest pending slot number
    function automatic slot_id_t pick_slot(input logic [NUM_SLOTS-1:0] req);
        slot_id_t s;
        s = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (req[i]) begin
                s = slot_id_t'(i);
            end
        end
        return s;
    endfunction

    assign next_slot = pick_slot(pending);
    assign next_wr   = (next_slot == SLOT_MAIN_RAM) && wr_req;

    // New work waits for a free tag and the end of the download
    assign start = (state == ARB_IDLE) && (|pending) && !queue_full && !downloading;

    always_ff @(posedge VB) begin
        if (rst) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (start) begin
                        state     <= ARB_REQ;
                        sdram_req <= 1'b1;
                    end
                end
                ARB_REQ: begin
                    if (sdram_ack) begin
                        state     <= ARB_IDLE;
                        sdram_req <= 1'b0;
                    end
                end
                default: begin
                    state     <= ARB_IDLE;
                    sdram_req <= 1'b0;
                end
            endcase
        end
    end

    // Bus fields stay frozen while the request waits
    always_ff @(posedge VB) begin
        if (start) begin
            sdram_addr   <= map_addr[next_slot];
            sdram_bank   <= map_bank[next_slot];
            sdram_rnw    <= ~next_wr;
            sdram_wrmask <= next_wr ? wr_mask : 2'b11;
            data_write   <= wr_data;
            cur_slot     <= next_slot;
            cur_lsb      <= map_lsb[next_slot];
        end
    end

    // Acknowledge cycle goes to both the address and return stages
    assign grant       = (state == ARB_REQ) && sdram_ack;
    assign grant_slot  = cur_slot;
    assign issue_write = ~sdram_rnw;
    assign issue_lsb   = cur_lsb;

endmodule

`default_nettype wire

//--- logic/slot_map.sv
// Address stage of the SDRAM multiplexer: catches client selects and holds mapped requests
`default_nettype none

module slot_map import cps_mem_pkg::*; (
    input  logic                 VB,
    input  logic                 rst,
    input  logic                 main_rom_cs,
    input  logic [20:0]          main_rom_addr,
    input  logic                 main_ram_cs,
    input  logic                 main_vram_cs,
    input  logic                 main_rnw,
    input  logic [16:0]          ram_addr,
    input  word_t                main_dout,
    input  logic [1:0]           dsn,
    input  logic                 gfx_cs,
    input  sdram_addr_t          gfx_addr,
    input  logic                 adpcm_cs,
    input  logic [17:0]          adpcm_addr,
    input  logic                 snd_cs,
    input  logic [15:0]          snd_addr,
    input  logic                 grant,
    input  slot_id_t             grant_slot,
    output logic [NUM_SLOTS-1:0] pending,
    output sdram_addr_t          map_addr [NUM_SLOTS],
    output bank_t                map_bank [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0] map_lsb,
    output logic                 wr_req,
    output logic [1:0]           wr_mask,
    output word_t                wr_data
);

    logic [NUM_SLOTS-1:0] cs;
    logic [NUM_SLOTS-1:0] cs_q;
    logic [NUM_SLOTS-1:0] cs_rise;
    logic [NUM_SLOTS-1:0] clr;
    sdram_addr_t          slot_addr [NUM_SLOTS];
    sdram_addr_t          ram_offset;

    assign cs[SLOT_MAIN_ROM] = main_rom_cs;
    assign cs[SLOT_MAIN_RAM] = main_ram_cs | main_vram_cs;
    assign cs[SLOT_GFX]      = gfx_cs;
    assign cs[SLOT_ADPCM]    = adpcm_cs;
    assign cs[SLOT_SOUND]    = snd_cs;

    assign cs_rise = cs & ~cs_q;
    assign clr     = NUM_SLOTS'(grant) << grant_slot;

    // Work RAM and VRAM share one slot
    assign ram_offset = main_ram_cs ? RAM_OFFSET : VRAM_OFFSET;

    // 8-bit clients drop bit 0, kept for the byte pick
    assign slot_addr[SLOT_MAIN_ROM] = {1'b0, main_rom_addr};
    assign slot_addr[SLOT_MAIN_RAM] = ram_offset + {5'd0, ram_addr};
    assign slot_addr[SLOT_GFX]      = GFX_OFFSET + gfx_addr;
    assign slot_addr[SLOT_ADPCM]    = ADPCM_OFFSET + {5'd0, adpcm_addr[17:1]};
    assign slot_addr[SLOT_SOUND]    = SOUND_OFFSET + {7'd0, snd_addr[15:1]};

    always_ff @(posedge VB) begin
        if (rst) begin
            cs_q    <= '0;
            pending <= '0;
        end else begin
            cs_q    <= cs;
            pending <= (pending & ~clr) | cs_rise;
        end
    end

    // Request payload, captured on the select edge
    always_ff @(posedge VB) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (cs_rise[i]) begin
                map_addr[i] <= slot_addr[i];
            end
        end
        if (cs_rise[SLOT_ADPCM]) begin
            map_lsb[SLOT_ADPCM] <= adpcm_addr[0];
        end
        if (cs_rise[SLOT_SOUND]) begin
            map_lsb[SLOT_SOUND] <= snd_addr[0];
        end
        if (cs_rise[SLOT_MAIN_RAM]) begin
            wr_req  <= ~main_rnw;
            wr_mask <= dsn;
            wr_data <= main_dout;
        end
    end

    // Wide clients never use the byte select
    assign map_lsb[SLOT_MAIN_ROM] = 1'b0;
    assign map_lsb[SLOT_MAIN_RAM] = 1'b0;
    assign map_lsb[SLOT_GFX]      = 1'b0;

    assign map_bank[SLOT_MAIN_ROM] = BANK_CPU;
    assign map_bank[SLOT_MAIN_RAM] = BANK_CPU;
    assign map_bank[SLOT_GFX]      = BANK_GFX;
    assign map_bank[SLOT_ADPCM]    = BANK_SOUND;
    assign map_bank[SLOT_SOUND]    = BANK_SOUND;

endmodule

`default_nettype wire

//--- logic/cps_mem_pkg.sv
// Shared memory map, slot numbering and types, imported by every module of the SDRAM multiplexer
`default_nettype none

package cps_mem_pkg;

    // SDRAM side widths
    typedef logic [21:0] sdram_addr_t;
    typedef logic [1:0]  bank_t;
    typedef logic [15:0] word_t;
    typedef logic [31:0] rdata_t;
    typedef logic [2:0]  slot_id_t;

    localparam int NUM_SLOTS = 5;

    // Lower slot number wins arbitration
    localparam slot_id_t SLOT_MAIN_ROM = 3'd0;
    localparam slot_id_t SLOT_MAIN_RAM = 3'd1;
    localparam slot_id_t SLOT_GFX      = 3'd2;
    localparam slot_id_t SLOT_ADPCM    = 3'd3;
    localparam slot_id_t SLOT_SOUND    = 3'd4;

    // Region starts, in SDRAM words
    localparam sdram_addr_t SOUND_OFFSET = 22'h00_0000;
    localparam sdram_addr_t ADPCM_OFFSET = 22'h01_0000;
    localparam sdram_addr_t RAM_OFFSET   = 22'h20_0000;
    localparam sdram_addr_t VRAM_OFFSET  = 22'h30_0000;
    localparam sdram_addr_t GFX_OFFSET   = 22'h00_0000;

    // Sound and ADPCM share bank 0
    localparam bank_t BANK_SOUND = 2'd0;
    localparam bank_t BANK_CPU   = 2'd1;
    localparam bank_t BANK_GFX   = 2'd2;

    // Reads allowed in flight at once
    localparam int TAG_DEPTH = 4;
    localparam int TAG_PTR_W = 2;

    typedef enum logic {
        ARB_IDLE,
        ARB_REQ
    } arb_state_t;

endpackage

`default_nettype wire
